//--- Makefile
SIM      := verilator
TOP      := icache_top_tb
FILELIST := icache_top.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(SIM) $(FLAGS) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- icache_data_banks.sv
/*
 * Data path of the instruction cache
 *   Two bank RAMs, words interleaved as bank = word offset + way
 *   Fetch reads both banks at the same word address
 *   Block fills are rotated by way before the write
 */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_data_banks (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        fetch_v_i,
  input  wire icache_pkg::page_off_t fetch_pkt_i,
  input  wire                        data_fill_v_i,
  input  wire icache_pkg::data_fill_s data_fill_i,
  output logic                       data_fill_yumi_o,
  output icache_pkg::instr_t [`ICACHE_ASSOC-1:0] bank_rd_o
);

  localparam int bank_addr_w = `ICACHE_INDEX_W + `ICACHE_WAY_W;
  localparam int rot_w       = $clog2(`ICACHE_BLOCK_W);

  icache_pkg::index_t                      fetch_index;
  // A block holds one word per bank
  logic [`ICACHE_WAY_W-1:0]                fetch_word;
  logic                                    bank_v;
  logic [rot_w-1:0]                        fill_rot;
  logic [2*`ICACHE_BLOCK_W-1:0]            fill_wide;
  icache_pkg::block_t                      fill_block_rot;
  icache_pkg::instr_t [`ICACHE_ASSOC-1:0]  fill_words;

  assign fetch_index = fetch_pkt_i[`ICACHE_PAGE_W-1 -: `ICACHE_INDEX_W];
  assign fetch_word  = fetch_pkt_i[`ICACHE_OFFSET_W-1 -: `ICACHE_WAY_W];

  // Same rule as the tag side, fetch first
  assign data_fill_yumi_o = data_fill_v_i & ~fetch_v_i;
  assign bank_v           = fetch_v_i | data_fill_yumi_o;

  //////////////////////////////
  // Fill rotation
  //////////////////////////////
  // Rotate left by way * bank width
  assign fill_rot       = rot_w'(data_fill_i.way) * rot_w'(`ICACHE_BANK_W);
  assign fill_wide      = {data_fill_i.block, data_fill_i.block} << fill_rot;
  assign fill_block_rot = fill_wide[2*`ICACHE_BLOCK_W-1 -: `ICACHE_BLOCK_W];
  assign fill_words     = fill_block_rot;

  //////////////////////////////
  // Banks
  //////////////////////////////
  for (genvar b = 0; b < `ICACHE_ASSOC; b++)
  begin : g_bank
    icache_pkg::way_t         fill_offset;
    logic [bank_addr_w-1:0]   bank_addr;

    // Bank b holds word (b - way) of the filled way
    assign fill_offset = icache_pkg::way_t'(b) - data_fill_i.way;
    assign bank_addr   = fetch_v_i ? {fetch_index, fetch_word}
                                   : {data_fill_i.index, fill_offset};

    icache_sram #(
      .width_p(`ICACHE_BANK_W),
      .els_p  (`ICACHE_SETS * `ICACHE_ASSOC)
    ) u_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (bank_v),
      .w_i     (data_fill_yumi_o),
      .addr_i  (bank_addr),
      .data_i  (fill_words[b]),
      .w_mask_i({`ICACHE_BANK_W{1'b1}}),
      .data_o  (bank_rd_o[b])
    );
  end

endmodule

`default_nettype wire

//--- icache_hit_select.sv
/*
 * Tag verify stage of the instruction cache
 *   Stage registers for the lookup result and both bank words
 *   One-hot bank select from hit way plus word offset
 *   Instruction, hit and miss outputs
 */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_hit_select (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire icache_pkg::tl_result_s tl_result_i,
  input  wire icache_pkg::instr_t [`ICACHE_ASSOC-1:0] bank_rd_i,
  output icache_pkg::instr_t          data_o,
  output logic                        data_v_o,
  output logic                        miss_v_o
);

  logic                                    v_tv_r;
  icache_pkg::tl_result_s                  tv_r;
  icache_pkg::instr_t [`ICACHE_ASSOC-1:0]  bank_tv_r;
  icache_pkg::way_mask_t                   word_oh;
  icache_pkg::way_mask_t                   bank_sel;

  //////////////////////////////
  // Stage registers
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_tv_r <= 1'b0;
    end
    else
    begin
      v_tv_r <= tl_result_i.v;
    end
  end

  // Bank outputs are still the fetch's read data here
  always_ff @(posedge clk_i)
  begin
    if (tl_result_i.v)
    begin
      tv_r      <= tl_result_i;
      bank_tv_r <= bank_rd_i;
    end
  end

  //////////////////////////////
  // Bank select
  //////////////////////////////
  always_comb
  begin
    for (int i = 0; i < `ICACHE_ASSOC; i++)
    begin
      word_oh[i] = (icache_pkg::way_t'(tv_r.word) == icache_pkg::way_t'(i));
    end
  end

  // One-hot sum, wraps around the bank count
  always_comb
  begin
    bank_sel = '0;
    for (int i = 0; i < `ICACHE_ASSOC; i++)
    begin
      for (int j = 0; j < `ICACHE_ASSOC; j++)
      begin
        if (tv_r.hit[i] && word_oh[j])
        begin
          bank_sel[(i + j) % `ICACHE_ASSOC] = 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    data_o = '0;
    for (int b = 0; b < `ICACHE_ASSOC; b++)
    begin
      data_o = data_o | (bank_tv_r[b] & {`ICACHE_BANK_W{bank_sel[b]}});
    end
  end

  assign data_v_o = v_tv_r & (|tv_r.hit);
  assign miss_v_o = v_tv_r & ~(|tv_r.hit);

endmodule

`default_nettype wire

//--- icache_macros.svh
/*
 * Geometry of the L1 instruction cache
 *   Set count, associativity and block and bank widths
 *   Bit widths of the fetch address fields and the physical tag
 */

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Array shape
`define ICACHE_SETS     512
`define ICACHE_ASSOC    2
`define ICACHE_BLOCK_W  64
// One bank per way, bank word is also the instruction
`define ICACHE_BANK_W   32

// Address fields, index and block offset fill the page offset
`define ICACHE_INDEX_W  9
`define ICACHE_WAY_W    1
`define ICACHE_OFFSET_W 3
`define ICACHE_PAGE_W   12
`define ICACHE_PTAG_W   8

`endif

//--- icache_pkg.sv
/*
 * Shared types of the instruction cache
 *   Vector typedefs for indices, tags, words and blocks
 *   Tag fill opcode
 *   Fill packets and the tag lookup result
 */

`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_WAY_W-1:0]   way_t;
  typedef logic [`ICACHE_ASSOC-1:0]   way_mask_t;
  typedef logic [`ICACHE_PTAG_W-1:0]  ptag_t;
  typedef logic [`ICACHE_PAGE_W-1:0]  page_off_t;
  typedef logic [`ICACHE_BANK_W-1:0]  instr_t;
  typedef logic [`ICACHE_BLOCK_W-1:0] block_t;

  // Invalidate is zero so a cleared row reads as invalid
  typedef enum logic {
    e_tag_invalid = 1'b0,
    e_tag_set     = 1'b1
  } tag_op_e;

  typedef struct packed {
    logic  v;
    ptag_t ptag;
  } tag_entry_s;

  typedef struct packed {
    tag_op_e op;
    index_t  index;
    way_t    way;
    ptag_t   ptag;
  } tag_fill_s;

  typedef struct packed {
    index_t index;
    way_t   way;
    block_t block;
  } data_fill_s;

  // Handed from tag lookup to tag verify
  typedef struct packed {
    logic      v;
    way_mask_t hit;
    logic      word;
    ptag_t     ptag;
  } tl_result_s;

endpackage

`default_nettype wire

//--- icache_sram.sv
/*
 * Single-port synchronous RAM
 *   One read or one write per cycle
 *   Bit-masked writes, read data held until the next read
 */

`timescale 1ns/10ps
`default_nettype none

module icache_sram #(
  parameter int width_p      = 32,
  parameter int els_p        = 1024,
  parameter int addr_width_p = $clog2(els_p)
) (
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  wire                    v_i,
  input  wire                    w_i,
  input  wire [addr_width_p-1:0] addr_i,
  input  wire [width_p-1:0]      data_i,
  input  wire [width_p-1:0]      w_mask_i,
  output logic [width_p-1:0]     data_o
);

  logic [width_p-1:0] mem_r [els_p];

  // Only masked bits change
  always_ff @(posedge clk_i)
  begin
    if (v_i && w_i)
    begin
      mem_r[addr_i] <= (mem_r[addr_i] & ~w_mask_i) | (data_i & w_mask_i);
    end
  end

  // Output latch keeps the last read across writes and idle cycles
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      data_o <= '0;
    end
    else if (v_i && !w_i)
    begin
      data_o <= mem_r[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- icache_tag_lookup.sv
/*
 * Tag path of the instruction cache
 *   Tag array with both ways in one row
 *   Decode to tag lookup stage register
 *   Tag compare against the incoming physical tag
 *   Tag fill arbitration against fetches
 */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_tag_lookup (
  input  wire                     clk_i,
  input  wire                     reset_i,
  input  wire                     fetch_v_i,
  input  wire icache_pkg::page_off_t fetch_pkt_i,
  input  wire icache_pkg::ptag_t  ptag_i,
  input  wire                     ptag_v_i,
  input  wire                     tag_fill_v_i,
  input  wire icache_pkg::tag_fill_s tag_fill_i,
  output logic                    tag_fill_yumi_o,
  output icache_pkg::tl_result_s  tl_result_o
);

  localparam int row_w = `ICACHE_ASSOC * $bits(icache_pkg::tag_entry_s);

  icache_pkg::index_t                          fetch_index;
  logic                                        fetch_word;
  logic                                        tag_v;
  logic                                        tag_w;
  icache_pkg::index_t                          tag_addr;
  icache_pkg::way_mask_t                       fill_way_oh;
  icache_pkg::tag_entry_s [`ICACHE_ASSOC-1:0]  row_wdata;
  icache_pkg::tag_entry_s [`ICACHE_ASSOC-1:0]  row_wmask;
  icache_pkg::tag_entry_s [`ICACHE_ASSOC-1:0]  row_rdata;
  logic                                        v_tl_r;
  logic                                        word_tl_r;
  icache_pkg::way_mask_t                       hit_tl;

  //////////////////////////////
  // Decode
  //////////////////////////////
  assign fetch_index = fetch_pkt_i[`ICACHE_PAGE_W-1 -: `ICACHE_INDEX_W];
  assign fetch_word  = fetch_pkt_i[`ICACHE_OFFSET_W-1];

  // Fills only get the array when no fetch is accepted
  assign tag_fill_yumi_o = tag_fill_v_i & ~fetch_v_i;
  assign tag_v    = fetch_v_i | tag_fill_yumi_o;
  assign tag_w    = tag_fill_yumi_o;
  assign tag_addr = fetch_v_i ? fetch_index : tag_fill_i.index;

  always_comb
  begin
    for (int i = 0; i < `ICACHE_ASSOC; i++)
    begin
      fill_way_oh[i]    = (tag_fill_i.way == icache_pkg::way_t'(i));
      row_wdata[i].v    = (tag_fill_i.op == icache_pkg::e_tag_set);
      row_wdata[i].ptag = row_wdata[i].v ? tag_fill_i.ptag : '0;
      // Whole entry of the target way only
      row_wmask[i]      = {$bits(icache_pkg::tag_entry_s){fill_way_oh[i]}};
    end
  end

  icache_sram #(
    .width_p(row_w),
    .els_p  (`ICACHE_SETS)
  ) u_tag_mem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (tag_v),
    .w_i     (tag_w),
    .addr_i  (tag_addr),
    .data_i  (row_wdata),
    .w_mask_i(row_wmask),
    .data_o  (row_rdata)
  );

  //////////////////////////////
  // Tag lookup
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_tl_r <= 1'b0;
    end
    else
    begin
      v_tl_r <= fetch_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_v_i)
    begin
      word_tl_r <= fetch_word;
    end
  end

  always_comb
  begin
    for (int i = 0; i < `ICACHE_ASSOC; i++)
    begin
      hit_tl[i] = row_rdata[i].v && (row_rdata[i].ptag == ptag_i);
    end
  end

  // A missing translation drops the fetch here
  assign tl_result_o = '{
    v:    v_tl_r & ptag_v_i,
    hit:  hit_tl,
    word: word_tl_r,
    ptag: ptag_i
  };

endmodule

`default_nettype wire

//--- icache_top.f
+incdir+.
icache_pkg.sv
icache_sram.sv
icache_tag_lookup.sv
icache_data_banks.sv
icache_hit_select.sv
icache_top.sv
icache_top_tb.sv

//--- icache_top.sv
/*
 * Instruction cache top level
 *   Tag path and data path in parallel
 *   Both feed the tag verify stage
 */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_top (
  input  wire                          clk_i,
  input  wire                          reset_i,
  // Decode
  input  wire                          fetch_v_i,
  input  wire icache_pkg::page_off_t   fetch_pkt_i,
  // Tag lookup
  input  wire icache_pkg::ptag_t       ptag_i,
  input  wire                          ptag_v_i,
  // Fills
  input  wire                          tag_fill_v_i,
  input  wire icache_pkg::tag_fill_s   tag_fill_i,
  output logic                         tag_fill_yumi_o,
  input  wire                          data_fill_v_i,
  input  wire icache_pkg::data_fill_s  data_fill_i,
  output logic                         data_fill_yumi_o,
  // Tag verify
  output icache_pkg::instr_t           data_o,
  output logic                         data_v_o,
  output logic                         miss_v_o
);

  icache_pkg::tl_result_s                  tl_result;
  icache_pkg::instr_t [`ICACHE_ASSOC-1:0]  bank_rd;

  icache_tag_lookup u_tag_lookup (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_v_i      (fetch_v_i),
    .fetch_pkt_i    (fetch_pkt_i),
    .ptag_i         (ptag_i),
    .ptag_v_i       (ptag_v_i),
    .tag_fill_v_i   (tag_fill_v_i),
    .tag_fill_i     (tag_fill_i),
    .tag_fill_yumi_o(tag_fill_yumi_o),
    .tl_result_o    (tl_result)
  );

  icache_data_banks u_data_banks (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_v_i       (fetch_v_i),
    .fetch_pkt_i     (fetch_pkt_i),
    .data_fill_v_i   (data_fill_v_i),
    .data_fill_i     (data_fill_i),
    .data_fill_yumi_o(data_fill_yumi_o),
    .bank_rd_o       (bank_rd)
  );

  icache_hit_select u_hit_select (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tl_result_i(tl_result),
    .bank_rd_i  (bank_rd),
    .data_o     (data_o),
    .data_v_o   (data_v_o),
    .miss_v_o   (miss_v_o)
  );

endmodule

`default_nettype wire

//--- icache_top_tb.sv
/*
 * Testbench of the instruction cache
 *   Reference model of tags and blocks per set and way
 *   Reference function for hit, miss and instruction
 *   LFSR stimulus, fill handshakes and a per-cycle compare queue
 */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_top_tb;

  typedef struct packed {
    logic               v;
    logic               hit;
    icache_pkg::instr_t data;
  } expect_s;

  // Invalidate pass, directed tests, preload and 60 random rounds
  localparam int planned_cycles = 2 + 1024 + 34 + 26 + 32 + 60 * 9 + 30;
  localparam int cycle_limit    = 2 * planned_cycles;

  logic                   clk_i;
  logic                   reset_i;
  logic                   fetch_v_i;
  icache_pkg::page_off_t  fetch_pkt_i;
  icache_pkg::ptag_t      ptag_i;
  logic                   ptag_v_i;
  logic                   tag_fill_v_i;
  icache_pkg::tag_fill_s  tag_fill_i;
  logic                   tag_fill_yumi_o;
  logic                   data_fill_v_i;
  icache_pkg::data_fill_s data_fill_i;
  logic                   data_fill_yumi_o;
  icache_pkg::instr_t     data_o;
  logic                   data_v_o;
  logic                   miss_v_o;

  // Model state updated at the edge where yumi is seen
  logic               m_valid [`ICACHE_SETS][`ICACHE_ASSOC];
  icache_pkg::ptag_t  m_tag   [`ICACHE_SETS][`ICACHE_ASSOC];
  icache_pkg::block_t m_block [`ICACHE_SETS][`ICACHE_ASSOC];

  expect_s            expect_q [$];
  logic [15:0]        lfsr_state;
  icache_pkg::ptag_t  pend_ptag;
  logic               pend_ptag_v;
  logic               tag_seen;
  logic               data_seen;
  logic               lookup_v;
  icache_pkg::index_t lookup_index;
  logic               lookup_word;
  int                 cycle_count = 0;

  icache_top u_icache_top (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_v_i       (fetch_v_i),
    .fetch_pkt_i     (fetch_pkt_i),
    .ptag_i          (ptag_i),
    .ptag_v_i        (ptag_v_i),
    .tag_fill_v_i    (tag_fill_v_i),
    .tag_fill_i      (tag_fill_i),
    .tag_fill_yumi_o (tag_fill_yumi_o),
    .data_fill_v_i   (data_fill_v_i),
    .data_fill_i     (data_fill_i),
    .data_fill_yumi_o(data_fill_yumi_o),
    .data_o          (data_o),
    .data_v_o        (data_v_o),
    .miss_v_o        (miss_v_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic icache_pkg::block_t rand_block();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(32);
    lo = rand_bits(32);
    return {hi, lo};
  endfunction

  // Expected outcome from the model state
  // Word 0 is the low half of a block
  function automatic expect_s predict(input icache_pkg::index_t idx, input logic word,
                                      input icache_pkg::ptag_t tag);
    expect_s r;
    r = '0;
    r.v = 1'b1;
    for (int w = 0; w < `ICACHE_ASSOC; w++)
    begin
      if (m_valid[idx][w] === 1'b1 && m_tag[idx][w] == tag)
      begin
        r.hit  = 1'b1;
        r.data = word ? m_block[idx][w][63:32] : m_block[idx][w][31:0];
      end
    end
    return r;
  endfunction

  // One cycle of fetch and the ptag of the previous fetch
  task automatic drive_cycle(input logic f_v, input icache_pkg::page_off_t pkt,
                             input icache_pkg::ptag_t tag, input logic tag_v);
    fetch_v_i   = f_v;
    fetch_pkt_i = pkt;
    ptag_i      = pend_ptag;
    ptag_v_i    = pend_ptag_v;
    pend_ptag   = tag;
    pend_ptag_v = f_v & tag_v;
    @(negedge clk_i);
  endtask

  task automatic idle();
    drive_cycle(1'b0, '0, '0, 1'b0);
  endtask

  task automatic fetch(input icache_pkg::index_t idx, input logic word,
                       input icache_pkg::ptag_t tag, input logic tag_v);
    logic [1:0] byte_off;
    byte_off = 2'(rand_bits(2));
    drive_cycle(1'b1, {idx, word, byte_off}, tag, tag_v);
  endtask

  task automatic start_fill(input logic do_tag, input icache_pkg::tag_fill_s tf,
                            input logic do_data, input icache_pkg::data_fill_s df);
    tag_fill_v_i  = do_tag;
    tag_fill_i    = tf;
    data_fill_v_i = do_data;
    data_fill_i   = df;
    tag_seen      = 1'b0;
    data_seen     = 1'b0;
  endtask

  // Hold the packets until each yumi has been seen
  task automatic finish_fill();
    while ((tag_fill_v_i && !tag_seen) || (data_fill_v_i && !data_seen))
    begin
      idle();
    end
    tag_fill_v_i  = 1'b0;
    data_fill_v_i = 1'b0;
  endtask

  function automatic icache_pkg::tag_fill_s make_tag(input icache_pkg::tag_op_e op,
                                                     input icache_pkg::index_t idx,
                                                     input logic way,
                                                     input icache_pkg::ptag_t tag);
    icache_pkg::tag_fill_s tf;
    tf.op    = op;
    tf.index = idx;
    tf.way   = way;
    tf.ptag  = tag;
    return tf;
  endfunction

  function automatic icache_pkg::data_fill_s make_data(input icache_pkg::index_t idx,
                                                       input logic way,
                                                       input icache_pkg::block_t blk);
    icache_pkg::data_fill_s df;
    df.index = idx;
    df.way   = way;
    df.block = blk;
    return df;
  endfunction

  //////////////////////////////
  // Model and prediction
  //////////////////////////////
  always @(posedge clk_i)
  begin : model_update
    expect_s e;
    // Fetch from the previous edge meets its ptag here
    e = '0;
    if (lookup_v && ptag_v_i)
    begin
      e = predict(lookup_index, lookup_word, ptag_i);
    end
    expect_q.push_back(e);
    lookup_v     = fetch_v_i & ~reset_i;
    lookup_index = fetch_pkt_i[`ICACHE_PAGE_W-1 -: `ICACHE_INDEX_W];
    lookup_word  = fetch_pkt_i[`ICACHE_OFFSET_W-1];

    assert (tag_fill_yumi_o === (tag_fill_v_i & ~fetch_v_i))
      else fail_run($sformatf("** Error at %0t: tag_fill_yumi_o is %b with fill valid %b, fetch %b",
                              $time, tag_fill_yumi_o, tag_fill_v_i, fetch_v_i));
    assert (data_fill_yumi_o === (data_fill_v_i & ~fetch_v_i))
      else fail_run($sformatf("** Error at %0t: data_fill_yumi_o is %b with fill valid %b, fetch %b",
                              $time, data_fill_yumi_o, data_fill_v_i, fetch_v_i));

    if (tag_fill_yumi_o)
    begin
      m_valid[tag_fill_i.index][tag_fill_i.way] = (tag_fill_i.op == icache_pkg::e_tag_set);
      m_tag[tag_fill_i.index][tag_fill_i.way]   = tag_fill_i.ptag;
      tag_seen = 1'b1;
    end
    if (data_fill_yumi_o)
    begin
      m_block[data_fill_i.index][data_fill_i.way] = data_fill_i.block;
      data_seen = 1'b1;
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  //////////////////////////////
  // Compare
  //////////////////////////////
  always @(negedge clk_i)
  begin : compare
    expect_s e;
    if (expect_q.size() > 0)
    begin
      e = expect_q.pop_front();
      assert (data_v_o === (e.v & e.hit))
        else fail_run($sformatf("** Error at %0t: data_v_o is %b, expected %b",
                                $time, data_v_o, e.v & e.hit));
      assert (miss_v_o === (e.v & ~e.hit))
        else fail_run($sformatf("** Error at %0t: miss_v_o is %b, expected %b",
                                $time, miss_v_o, e.v & ~e.hit));
      if (e.v && e.hit)
      begin
        assert (data_o === e.data)
          else fail_run($sformatf("** Error at %0t: data_o is %h, expected %h",
                                  $time, data_o, e.data));
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial
  begin : stimulus
    icache_pkg::index_t idx;
    icache_pkg::block_t blk;
    icache_pkg::ptag_t  tag;
    icache_pkg::tag_op_e op;
    logic               way;
    int                 k;

    lfsr_state    = 16'd44751;
    reset_i       = 1'b1;
    fetch_v_i     = 1'b0;
    fetch_pkt_i   = '0;
    ptag_i        = '0;
    ptag_v_i      = 1'b0;
    tag_fill_v_i  = 1'b0;
    tag_fill_i    = '0;
    data_fill_v_i = 1'b0;
    data_fill_i   = '0;
    pend_ptag     = '0;
    pend_ptag_v   = 1'b0;
    tag_seen      = 1'b0;
    data_seen     = 1'b0;
    lookup_v      = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Every way of every set starts invalid
    for (int s = 0; s < `ICACHE_SETS; s++)
    begin
      for (int w = 0; w < `ICACHE_ASSOC; w++)
      begin
        start_fill(1'b1, make_tag(icache_pkg::e_tag_invalid, 9'(s), w[0], '0), 1'b0, '0);
        finish_fill();
      end
    end

    // Cold cache misses everywhere
    repeat (32) fetch(9'(rand_bits(9)), rand_bits(1) != 0, 8'(rand_bits(8)), 1'b1);
    repeat (2) idle();

    // Both words of a filled way across both banks
    for (int i = 0; i < 8; i++)
    begin
      idx = 9'(64 * i) | 9'(rand_bits(6));
      way = i[0];
      tag = 8'(rand_bits(8));
      start_fill(1'b1, make_tag(icache_pkg::e_tag_set, idx, way, tag),
                 1'b1, make_data(idx, way, rand_block()));
      finish_fill();
      fetch(idx, 1'b0, tag, 1'b1);
      fetch(idx, 1'b1, tag, 1'b1);
    end
    repeat (2) idle();

    // Preload sets 0x160 to 0x16f
    // Tag lsb equal to the way keeps ways apart
    for (int i = 0; i < 16; i++)
    begin
      for (int w = 0; w < `ICACHE_ASSOC; w++)
      begin
        idx = {5'h16, i[3:0]};
        tag = {6'b101001, rand_bits(1) != 0, w[0]};
        start_fill(1'b1, make_tag(icache_pkg::e_tag_set, idx, w[0], tag),
                   1'b1, make_data(idx, w[0], rand_block()));
        finish_fill();
      end
    end

    // Fetch bursts that starve a held fill with some ptags missing
    for (int r = 0; r < 60; r++)
    begin
      k   = 1 + int'(rand_bits(3));
      idx = {5'h16, 4'(rand_bits(4))};
      way = rand_bits(1) != 0;
      tag = {6'b101001, rand_bits(1) != 0, way};
      op  = (rand_bits(3) == 0) ? icache_pkg::e_tag_invalid : icache_pkg::e_tag_set;
      blk = rand_block();
      start_fill(1'b1, make_tag(op, idx, way, tag), 1'b1, make_data(idx, way, blk));
      repeat (k)
      begin
        fetch({5'h16, 4'(rand_bits(4))}, rand_bits(1) != 0,
              {6'b101001, 2'(rand_bits(2))}, rand_bits(3) != 0);
      end
      finish_fill();
    end

    // Invalidate one way while the other keeps hitting
    idx = 9'h0a5;
    start_fill(1'b1, make_tag(icache_pkg::e_tag_set, idx, 1'b0, 8'h3c),
               1'b1, make_data(idx, 1'b0, rand_block()));
    finish_fill();
    start_fill(1'b1, make_tag(icache_pkg::e_tag_set, idx, 1'b1, 8'hc3),
               1'b1, make_data(idx, 1'b1, rand_block()));
    finish_fill();
    fetch(idx, 1'b0, 8'h3c, 1'b1);
    fetch(idx, 1'b1, 8'hc3, 1'b1);
    start_fill(1'b1, make_tag(icache_pkg::e_tag_invalid, idx, 1'b0, '0), 1'b0, '0);
    finish_fill();
    fetch(idx, 1'b1, 8'h3c, 1'b1);
    fetch(idx, 1'b0, 8'hc3, 1'b1);

    // Missing translation drops the fetch
    fetch(idx, 1'b0, 8'hc3, 1'b0);
    fetch(idx, 1'b1, 8'hc3, 1'b1);
    repeat (3) idle();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
